// ==== build.f ====
rtl/y86_pkg.sv
rtl/y86_fetch.sv
rtl/y86_decode.sv
rtl/y86_regfile.sv
rtl/y86_execute.sv
rtl/y86_mem_stage.sv
rtl/y86_core.sv
verif/y86_tb_clk.sv
verif/y86_props.sv
verif/y86_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= y86_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/y86_tb.sv ====
`timescale 1ns/100ps

module y86_tb import y86_pkg::*; ();

    localparam int RUN_TIMEOUT = 200;
    localparam int RST_TIMEOUT = 10;

    localparam logic [3:0] EAX = 4'd0;
    localparam logic [3:0] ECX = 4'd1;
    localparam logic [3:0] EDX = 4'd2;
    localparam logic [3:0] EBX = 4'd3;
    localparam logic [3:0] ESP = REG_RSP;
    localparam logic [3:0] EBP = 4'd5;
    localparam logic [3:0] ESI = 4'd6;
    localparam logic [3:0] EDI = 4'd7;

    logic        clk;
    logic        rst_n;
    logic        rst_req = 1'b0;
    logic [3:0]  dbg_sel = 4'd0;
    logic [47:0] imem_data;
    logic [31:0] dmem_rdata;
    logic [15:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic        dmem_re;
    logic [15:0] pc;
    stat_e       stat;
    logic        halted;
    logic [31:0] dbg_val;

    logic [7:0]  imem [0:65535];
    logic [7:0]  dmem [0:4095];
    logic        dmem_clear = 1'b0;
    logic [7:0]  prog [0:255];
    int          asm_pc;
    int          n_checks = 0;
    int          n_errors = 0;

    y86_tb_clk u_clk (
        .rst_req_i (rst_req),
        .clk_o     (clk),
        .rst_n_o   (rst_n)
    );

    y86_core #(
        .IMEM_ADDR_W  (16)
    ) u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .imem_data_i  (imem_data),
        .dmem_rdata_i (dmem_rdata),
        .dbg_sel_i    (dbg_sel),
        .imem_addr_o  (imem_addr),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_re_o    (dmem_re),
        .pc_o         (pc),
        .stat_o       (stat),
        .halted_o     (halted),
        .dbg_val_o    (dbg_val)
    );

    // Both memories answer in the same cycle, little-endian.
    assign imem_data = {imem[imem_addr + 16'd5], imem[imem_addr + 16'd4],
                        imem[imem_addr + 16'd3], imem[imem_addr + 16'd2],
                        imem[imem_addr + 16'd1], imem[imem_addr]};
    assign dmem_rdata = {dmem[dmem_addr[11:0] + 12'd3], dmem[dmem_addr[11:0] + 12'd2],
                         dmem[dmem_addr[11:0] + 12'd1], dmem[dmem_addr[11:0]]};

    always @(posedge clk) begin
        if (dmem_clear) begin
            for (int i = 0; i < 4096; i++) begin
                dmem[i] <= 8'h00;
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[11:0]]         <= dmem_wdata[7:0];
            dmem[dmem_addr[11:0] + 12'd1] <= dmem_wdata[15:8];
            dmem[dmem_addr[11:0] + 12'd2] <= dmem_wdata[23:16];
            dmem[dmem_addr[11:0] + 12'd3] <= dmem_wdata[31:24];
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic expect_reg(input string name, input logic [3:0] id, input logic [31:0] exp);
        @(posedge clk);
        dbg_sel <= id;
        @(negedge clk);
        check_val(name, dbg_val, exp);
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            prog[i] = 8'h00;
        end
        asm_pc = 0;
    endtask

    task automatic emit_byte(input logic [7:0] b);
        prog[asm_pc] = b;
        asm_pc++;
    endtask

    // irmovl, rmmovl and mrmovl.
    task automatic imm_insn(input logic [3:0] icode, input logic [3:0] ra,
                            input logic [3:0] rb, input logic [31:0] val);
        emit_byte({icode, 4'h0});
        emit_byte({ra, rb});
        for (int k = 0; k < 4; k++) begin
            emit_byte(val[8*k +: 8]);
        end
    endtask

    task automatic rr_insn(input logic [3:0] icode, input logic [3:0] ifun,
                           input logic [3:0] ra, input logic [3:0] rb);
        emit_byte({icode, ifun});
        emit_byte({ra, rb});
    endtask

    task automatic jump_insn(input logic [3:0] icode, input logic [3:0] ifun,
                             input logic [31:0] dest);
        emit_byte({icode, ifun});
        for (int k = 0; k < 4; k++) begin
            emit_byte(dest[8*k +: 8]);
        end
    endtask

    // Fills imem with halt behind a pushl at 0, pulses reset and loads the program
    // once reset is released.
    task automatic reset_core(input bit check_state);
        int low_cycles;
        int waited;
        for (int i = 0; i < 65536; i++) begin
            imem[i] = 8'h00;
        end
        imem[0] = {I_PUSHL, 4'h0};               // Strobes if reset lets it commit.
        imem[1] = {EAX, REG_NONE};
        @(posedge clk);
        rst_req    <= 1'b1;
        dmem_clear <= 1'b1;
        @(posedge clk);
        rst_req    <= 1'b0;
        dmem_clear <= 1'b0;
        low_cycles = 0;
        waited     = 0;
        while (!(rst_n && low_cycles > 0) && waited < RST_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (!rst_n) begin
                low_cycles++;
                if (check_state && low_cycles == 2) begin
                    check_val("pc_o in reset", 32'(pc), 32'h0);
                    check_val("stat_o in reset", 32'(stat), 32'(AOK));
                    check_val("dmem_we_o in reset", 32'(dmem_we), 32'h0);
                    check_val("dmem_re_o in reset", 32'(dmem_re), 32'h0);
                end
            end
        end
        if (!(rst_n && low_cycles > 0)) begin
            n_errors++;
            $display("Reset was not released within %0d cycles", RST_TIMEOUT);
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = prog[i];
        end
    endtask

    task automatic run_program(input bit check_reset);
        int cycles;
        reset_core(check_reset);
        cycles = 0;
        while (!halted && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            n_errors++;
            $display("Core did not stop within %0d cycles", RUN_TIMEOUT);
        end
    endtask

    task automatic reset_and_halt();
        clear_program();
        emit_byte({I_NOP, 4'h0});
        emit_byte({I_NOP, 4'h0});
        emit_byte({I_NOP, 4'h0});
        emit_byte({I_HALT, 4'h0});
        run_program(1'b1);
        check_val("pc_o at halt", 32'(pc), 32'd3);
        check_val("stat_o at halt", 32'(stat), 32'(HLT));
    endtask

    task automatic arith_and_branch(input int iter);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] diff;
        logic        zf;
        logic        lt;
        int          jmp_pos;
        a    = $urandom();
        b    = (iter == 0) ? a : $urandom();
        diff = b - a;
        zf   = (a == b);
        lt   = ($signed(b) < $signed(a));        // Signed b below a.
        clear_program();
        imm_insn(I_IRMOVL, REG_NONE, EAX, a);
        imm_insn(I_IRMOVL, REG_NONE, ECX, b);
        rr_insn(I_CMOVXX, C_ALWAYS, ECX, EDX);
        rr_insn(I_CMOVXX, C_ALWAYS, ECX, EBX);
        rr_insn(I_CMOVXX, C_ALWAYS, ECX, ESI);
        rr_insn(I_CMOVXX, C_ALWAYS, ECX, EDI);
        rr_insn(I_OPL, ALU_ADD, EAX, ECX);
        rr_insn(I_OPL, ALU_AND, EAX, EBX);
        rr_insn(I_OPL, ALU_XOR, EAX, ESI);
        rr_insn(I_OPL, ALU_SUB, EAX, EDX);    // Last flags come from b - a.
        rr_insn(I_CMOVXX, C_E, ECX, EDI);
        rr_insn(I_CMOVXX, C_L, ECX, EBP);
        jmp_pos = asm_pc;
        jump_insn(I_JXX, C_L, 32'(jmp_pos + 12));
        imm_insn(I_IRMOVL, REG_NONE, ESP, 32'h11);
        emit_byte({I_HALT, 4'h0});
        imm_insn(I_IRMOVL, REG_NONE, ESP, 32'h22);
        emit_byte({I_HALT, 4'h0});
        run_program(1'b0);
        expect_reg("ecx (addl)", ECX, b + a);
        expect_reg("edx (subl)", EDX, diff);
        expect_reg("ebx (andl)", EBX, b & a);
        expect_reg("esi (xorl)", ESI, b ^ a);
        expect_reg("edi (cmove)", EDI, zf ? (b + a) : b);
        expect_reg("ebp (cmovl)", EBP, lt ? (b + a) : 32'h0);
        expect_reg("esp (jl path)", ESP, lt ? 32'h22 : 32'h11);
        check_val("pc_o after jl", 32'(pc), 32'(lt ? jmp_pos + 18 : jmp_pos + 11));
    endtask

    task automatic load_store();
        logic [31:0] word;
        logic [31:0] base;
        logic [31:0] disp;
        logic [31:0] addr;
        word = $urandom();
        base = 32'h100 + ($urandom() % 64) * 4;
        disp = ($urandom() % 32) * 4;
        addr = base + disp;
        clear_program();
        imm_insn(I_IRMOVL, REG_NONE, EAX, word);
        imm_insn(I_IRMOVL, REG_NONE, EBX, base);
        imm_insn(I_RMMOVL, EAX, EBX, disp);
        imm_insn(I_MRMOVL, ECX, EBX, disp);
        emit_byte({I_HALT, 4'h0});
        run_program(1'b0);
        expect_reg("ecx (mrmovl)", ECX, word);
        for (int k = 0; k < 4; k++) begin
            check_val($sformatf("dmem[0x%03h]", addr + k), 32'(dmem[12'(addr + k)]),
                      32'(word[8*k +: 8]));
        end
    endtask

    task automatic stack_and_calls();
        logic [31:0] v;
        logic [31:0] w;
        int          call_pos;
        v = $urandom();
        w = $urandom();
        clear_program();
        imm_insn(I_IRMOVL, REG_NONE, ESP, 32'h800);
        imm_insn(I_IRMOVL, REG_NONE, EAX, v);
        rr_insn(I_PUSHL, 4'h0, EAX, REG_NONE);
        rr_insn(I_POPL, 4'h0, ECX, REG_NONE);
        rr_insn(I_CMOVXX, C_ALWAYS, ESP, EDI);
        call_pos = asm_pc;
        jump_insn(I_CALL, 4'h0, 32'(call_pos + 28));    // Subroutine sits after the halt.
        imm_insn(I_IRMOVL, REG_NONE, EDX, 32'h33);
        imm_insn(I_IRMOVL, REG_NONE, ESP, 32'h700);
        imm_insn(I_IRMOVL, REG_NONE, ESI, w);
        rr_insn(I_PUSHL, 4'h0, ESI, REG_NONE);
        rr_insn(I_POPL, 4'h0, ESP, REG_NONE);
        emit_byte({I_HALT, 4'h0});
        imm_insn(I_IRMOVL, REG_NONE, EBX, 32'h44);
        emit_byte({I_RET, 4'h0});
        run_program(1'b0);
        expect_reg("ecx (popl)", ECX, v);
        expect_reg("edi (esp after push/pop)", EDI, 32'h800);
        expect_reg("ebx (in subroutine)", EBX, 32'h44);
        expect_reg("edx (after ret)", EDX, 32'h33);
        expect_reg("esp (popl %esp)", ESP, w);
        check_val("return address at 0x7fc", {dmem[12'h7ff], dmem[12'h7fe], dmem[12'h7fd],
                  dmem[12'h7fc]}, 32'(call_pos + 5));
        check_val("pc_o at halt", 32'(pc), 32'(call_pos + 27));
    endtask

    task automatic invalid_opcode();
        logic [31:0] x;
        logic [31:0] y;
        x = $urandom();
        y = $urandom();
        clear_program();
        imm_insn(I_IRMOVL, REG_NONE, EAX, x);
        emit_byte(8'hc0);                         // No such icode.
        imm_insn(I_IRMOVL, REG_NONE, ECX, y);
        emit_byte({I_HALT, 4'h0});
        run_program(1'b0);
        check_val("stat_o on fault", 32'(stat), 32'(INS));
        check_val("pc_o on fault", 32'(pc), 32'd6);
        expect_reg("eax (before fault)", EAX, x);
        expect_reg("ecx (after fault)", ECX, 32'h0);
        check_val("pc_o held after fault", 32'(pc), 32'd6);
    endtask

    initial begin
        void'($urandom(21996));
        reset_and_halt();
        for (int i = 0; i < 4; i++) begin
            arith_and_branch(i);
        end
        load_store();
        stack_and_calls();
        invalid_opcode();
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 n_checks, n_errors, u_dut.u_props.fail_cnt);
        if (n_errors == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verif/y86_props.sv ====
`timescale 1ns/100ps

module y86_props #(
    parameter int IMEM_ADDR_W = 16
) (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   we_i,
    input logic                   re_i,
    input logic                   commit_i,
    input logic                   halted_i,
    input logic [IMEM_ADDR_W-1:0] pc_i
);

    int fail_cnt = 0;                            // Failures seen so far.

    strobe_exclusive: assert property (@(posedge clk_i) !(we_i && re_i))
        else begin
            fail_cnt++;
            $error("data memory read and write strobes high in the same cycle");
        end

    halted_pc_hold: assert property (@(posedge clk_i) (halted_i && rst_n_i) |=> $stable(pc_i))
        else begin
            fail_cnt++;
            $error("PC moved while the core was stopped");
        end

    halted_no_write: assert property (@(posedge clk_i) halted_i |-> !(commit_i || we_i || re_i))
        else begin
            fail_cnt++;
            $error("write or memory access while the core was stopped");
        end

    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !(we_i || re_i))
        else begin
            fail_cnt++;
            $error("data memory strobe active during reset");
        end

endmodule

bind y86_core y86_props #(
    .IMEM_ADDR_W (IMEM_ADDR_W)
) u_props (
    .clk_i       (clk),
    .rst_n_i     (rst_n_i),
    .we_i        (dmem_we_o),
    .re_i        (dmem_re_o),
    .commit_i    (commit),
    .halted_i    (halted_o),
    .pc_i        (pc_o)
);

// ==== verif/y86_tb_clk.sv ====
`timescale 1ns/100ps

module y86_tb_clk (
    input  logic rst_req_i,
    output logic clk_o,
    output logic rst_n_o
);

    logic       clk_q    = 1'b0;
    logic       rst_n_q  = 1'b0;
    logic [1:0] hold_cnt = 2'd2;

    always #5 clk_q = ~clk_q;                    // 10 ns period.

    // Reset stays low for two rising edges after power up or a request.
    always @(posedge clk_q) begin
        if (rst_req_i) begin
            rst_n_q  <= 1'b0;
            hold_cnt <= 2'd2;
        end else if (hold_cnt != 2'd0) begin
            hold_cnt <= hold_cnt - 2'd1;
            if (hold_cnt == 2'd1) begin
                rst_n_q <= 1'b1;
            end
        end
    end

    assign clk_o   = clk_q;
    assign rst_n_o = rst_n_q;

endmodule

// ==== rtl/y86_core.sv ====
`timescale 1ns/100ps

module y86_core import y86_pkg::*; #(
    parameter int IMEM_ADDR_W = 16
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [INST_W-1:0]      imem_data_i,
    input  logic [WORD_W-1:0]      dmem_rdata_i,
    input  logic [REG_W-1:0]       dbg_sel_i,
    output logic [IMEM_ADDR_W-1:0] imem_addr_o,
    output logic [WORD_W-1:0]      dmem_addr_o,
    output logic [WORD_W-1:0]      dmem_wdata_o,
    output logic                   dmem_we_o,
    output logic                   dmem_re_o,
    output logic [IMEM_ADDR_W-1:0] pc_o,
    output stat_e                  stat_o,
    output logic                   halted_o,
    output logic [WORD_W-1:0]      dbg_val_o
);

    logic [IMEM_ADDR_W-1:0] pc;
    logic [WORD_W-1:0]      pc_word;
    stat_e                  stat;
    logic                   commit;
    icode_e                 icode;
    logic [3:0]             ifun;
    logic                   instr_valid;
    logic [REG_W-1:0]       src_a;
    logic [REG_W-1:0]       src_b;
    logic [REG_W-1:0]       dst_e_raw;
    logic [REG_W-1:0]       dst_e;
    logic [REG_W-1:0]       dst_m;
    logic [WORD_W-1:0]      valc;
    logic [WORD_W-1:0]      valp;
    logic [WORD_W-1:0]      val_a;
    logic [WORD_W-1:0]      val_b;
    logic [WORD_W-1:0]      val_e;
    logic [WORD_W-1:0]      valm;
    logic                   cnd;

    assign pc_word = {{(WORD_W-IMEM_ADDR_W){1'b0}}, pc};

    y86_fetch #(
        .IMEM_ADDR_W   (IMEM_ADDR_W)
    ) u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .icode_i       (icode),
        .instr_valid_i (instr_valid),
        .cnd_i         (cnd),
        .valc_i        (valc),
        .valp_i        (valp),
        .valm_i        (valm),
        .pc_o          (pc),
        .stat_o        (stat),
        .commit_o      (commit)
    );

    y86_decode u_decode (
        .inst_i        (imem_data_i),
        .pc_i          (pc_word),
        .icode_o       (icode),
        .ifun_o        (ifun),
        .instr_valid_o (instr_valid),
        .src_a_o       (src_a),
        .src_b_o       (src_b),
        .dst_e_o       (dst_e_raw),
        .dst_m_o       (dst_m),
        .valc_o        (valc),
        .valp_o        (valp)
    );

    y86_regfile u_regfile (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .src_a_i       (src_a),
        .src_b_i       (src_b),
        .dst_e_i       (dst_e),
        .val_e_i       (val_e),
        .dst_m_i       (dst_m),
        .val_m_i       (valm),
        .we_i          (commit),
        .dbg_sel_i     (dbg_sel_i),
        .val_a_o       (val_a),
        .val_b_o       (val_b),
        .dbg_val_o     (dbg_val_o)
    );

    y86_execute u_execute (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .icode_i       (icode),
        .ifun_i        (ifun),
        .val_a_i       (val_a),
        .val_b_i       (val_b),
        .valc_i        (valc),
        .dst_e_i       (dst_e_raw),
        .commit_i      (commit),
        .val_e_o       (val_e),
        .cnd_o         (cnd),
        .dst_e_o       (dst_e)
    );

    y86_mem_stage u_mem_stage (
        .icode_i       (icode),
        .val_e_i       (val_e),
        .val_a_i       (val_a),
        .valp_i        (valp),
        .commit_i      (commit),
        .dmem_rdata_i  (dmem_rdata_i),
        .dmem_addr_o   (dmem_addr_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .dmem_we_o     (dmem_we_o),
        .dmem_re_o     (dmem_re_o),
        .valm_o        (valm)
    );

    assign imem_addr_o = pc;
    assign pc_o        = pc;
    assign stat_o      = stat;
    assign halted_o    = (stat != AOK);      // HLT or INS.

endmodule

// ==== rtl/y86_mem_stage.sv ====
`timescale 1ns/100ps

module y86_mem_stage import y86_pkg::*; (
    input  icode_e            icode_i,
    input  logic [WORD_W-1:0] val_e_i,
    input  logic [WORD_W-1:0] val_a_i,
    input  logic [WORD_W-1:0] valp_i,
    input  logic              commit_i,
    input  logic [WORD_W-1:0] dmem_rdata_i,
    output logic [WORD_W-1:0] dmem_addr_o,
    output logic [WORD_W-1:0] dmem_wdata_o,
    output logic              dmem_we_o,
    output logic              dmem_re_o,
    output logic [WORD_W-1:0] valm_o
);

    logic is_write;
    logic is_read;

    assign is_write = (icode_i == I_RMMOVL) || (icode_i == I_PUSHL) || (icode_i == I_CALL);
    assign is_read  = (icode_i == I_MRMOVL) || (icode_i == I_POPL) || (icode_i == I_RET);

    // Pop and ret read at the old stack pointer.
    assign dmem_addr_o = ((icode_i == I_POPL) || (icode_i == I_RET)) ? val_a_i : val_e_i;

    assign dmem_wdata_o = (icode_i == I_CALL) ? valp_i : val_a_i;  // Return address.

    assign dmem_we_o = commit_i & is_write;
    assign dmem_re_o = commit_i & is_read;

    assign valm_o = dmem_rdata_i;

endmodule

// ==== rtl/y86_execute.sv ====
`timescale 1ns/100ps

module y86_execute import y86_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  icode_e            icode_i,
    input  logic [3:0]        ifun_i,
    input  logic [WORD_W-1:0] val_a_i,
    input  logic [WORD_W-1:0] val_b_i,
    input  logic [WORD_W-1:0] valc_i,
    input  logic [REG_W-1:0]  dst_e_i,
    input  logic              commit_i,
    output logic [WORD_W-1:0] val_e_o,
    output logic              cnd_o,
    output logic [REG_W-1:0]  dst_e_o
);

    logic [WORD_W-1:0] alu_a;
    logic [WORD_W-1:0] alu_b;
    alu_fn_e           alu_fn;
    logic [WORD_W-1:0] alu_res;
    logic              alu_of;
    logic              zf_q;
    logic              sf_q;
    logic              of_q;
    logic              lt;

    always_comb begin
        alu_a  = valc_i;
        alu_b  = '0;
        alu_fn = ALU_ADD;
        case (icode_i)
            I_CMOVXX: alu_a = val_a_i;
            I_RMMOVL, I_MRMOVL: alu_b = val_b_i;
            I_OPL: begin
                alu_a  = val_a_i;
                alu_b  = val_b_i;
                alu_fn = alu_fn_e'(ifun_i);
            end
            I_PUSHL, I_CALL: begin
                alu_a = 32'hffff_fffc;           // Stack grows down.
                alu_b = val_b_i;
            end
            I_POPL, I_RET: begin
                alu_a = 32'd4;
                alu_b = val_b_i;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (alu_fn)
            ALU_ADD: alu_res = alu_b + alu_a;
            ALU_SUB: alu_res = alu_b - alu_a;
            ALU_AND: alu_res = alu_b & alu_a;
            ALU_XOR: alu_res = alu_b ^ alu_a;
            default: alu_res = '0;
        endcase
        case (alu_fn)
            ALU_ADD: alu_of = (alu_a[31] == alu_b[31]) && (alu_res[31] != alu_b[31]);
            ALU_SUB: alu_of = (alu_a[31] != alu_b[31]) && (alu_res[31] != alu_b[31]);
            default: alu_of = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            zf_q <= 1'b1;
            sf_q <= 1'b0;
            of_q <= 1'b0;
        end else if (commit_i && (icode_i == I_OPL)) begin
            zf_q <= (alu_res == '0);
            sf_q <= alu_res[31];
            of_q <= alu_of;
        end
    end

    assign lt = sf_q ^ of_q;

    always_comb begin
        case (cond_fn_e'(ifun_i))
            C_ALWAYS: cnd_o = 1'b1;
            C_LE:     cnd_o = lt | zf_q;
            C_L:      cnd_o = lt;
            C_E:      cnd_o = zf_q;
            C_NE:     cnd_o = ~zf_q;
            C_GE:     cnd_o = ~lt;
            C_G:      cnd_o = ~lt & ~zf_q;
            default:  cnd_o = 1'b0;
        endcase
    end

    assign val_e_o = alu_res;
    assign dst_e_o = ((icode_i == I_CMOVXX) && !cnd_o) ? REG_NONE : dst_e_i;  // Cancelled cmov.

endmodule

// ==== rtl/y86_regfile.sv ====
`timescale 1ns/100ps

module y86_regfile import y86_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [REG_W-1:0]  src_a_i,
    input  logic [REG_W-1:0]  src_b_i,
    input  logic [REG_W-1:0]  dst_e_i,
    input  logic [WORD_W-1:0] val_e_i,
    input  logic [REG_W-1:0]  dst_m_i,
    input  logic [WORD_W-1:0] val_m_i,
    input  logic              we_i,
    input  logic [REG_W-1:0]  dbg_sel_i,
    output logic [WORD_W-1:0] val_a_o,
    output logic [WORD_W-1:0] val_b_o,
    output logic [WORD_W-1:0] dbg_val_o
);

    logic [WORD_W-1:0] regs [0:7];

    // Ids 8 and up, including none, read as zero.
    assign val_a_o   = src_a_i[3] ? '0 : regs[src_a_i[2:0]];
    assign val_b_o   = src_b_i[3] ? '0 : regs[src_b_i[2:0]];
    assign dbg_val_o = dbg_sel_i[3] ? '0 : regs[dbg_sel_i[2:0]];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            if (!dst_e_i[3]) begin
                regs[dst_e_i[2:0]] <= val_e_i;
            end
            if (!dst_m_i[3]) begin
                regs[dst_m_i[2:0]] <= val_m_i;   // M write wins a clash.
            end
        end
    end

endmodule

// ==== rtl/y86_decode.sv ====
`timescale 1ns/100ps

module y86_decode import y86_pkg::*; (
    input  logic [INST_W-1:0] inst_i,
    input  logic [WORD_W-1:0] pc_i,
    output icode_e            icode_o,
    output logic [3:0]        ifun_o,
    output logic              instr_valid_o,
    output logic [REG_W-1:0]  src_a_o,
    output logic [REG_W-1:0]  src_b_o,
    output logic [REG_W-1:0]  dst_e_o,
    output logic [REG_W-1:0]  dst_m_o,
    output logic [WORD_W-1:0] valc_o,
    output logic [WORD_W-1:0] valp_o
);

    logic [REG_W-1:0] ra;
    logic [REG_W-1:0] rb;
    logic [2:0]       len;

    assign icode_o = icode_e'(inst_i[7:4]);
    assign ifun_o  = inst_i[3:0];
    assign ra      = inst_i[15:12];
    assign rb      = inst_i[11:8];

    assign instr_valid_o = (inst_i[7:4] <= 4'hb);

    always_comb begin
        src_a_o = REG_NONE;
        src_b_o = REG_NONE;
        dst_e_o = REG_NONE;
        dst_m_o = REG_NONE;
        valc_o  = '0;
        len     = 3'd1;                          // halt, nop, ret.
        case (icode_o)
            I_CMOVXX: begin
                src_a_o = ra;
                dst_e_o = rb;
                len     = 3'd2;
            end
            I_IRMOVL: begin
                dst_e_o = rb;
                valc_o  = inst_i[47:16];
                len     = 3'd6;
            end
            I_RMMOVL: begin
                src_a_o = ra;
                src_b_o = rb;
                valc_o  = inst_i[47:16];
                len     = 3'd6;
            end
            I_MRMOVL: begin
                src_b_o = rb;
                dst_m_o = ra;
                valc_o  = inst_i[47:16];
                len     = 3'd6;
            end
            I_OPL: begin
                src_a_o = ra;
                src_b_o = rb;
                dst_e_o = rb;
                len     = 3'd2;
            end
            I_JXX: begin
                valc_o = inst_i[39:8];          // Destination follows byte 0.
                len    = 3'd5;
            end
            I_CALL: begin
                src_b_o = REG_RSP;
                dst_e_o = REG_RSP;
                valc_o  = inst_i[39:8];
                len     = 3'd5;
            end
            I_RET: begin
                src_a_o = REG_RSP;
                src_b_o = REG_RSP;
                dst_e_o = REG_RSP;
            end
            I_PUSHL: begin
                src_a_o = ra;
                src_b_o = REG_RSP;
                dst_e_o = REG_RSP;
                len     = 3'd2;
            end
            I_POPL: begin
                src_a_o = REG_RSP;
                src_b_o = REG_RSP;
                dst_e_o = REG_RSP;
                dst_m_o = ra;
                len     = 3'd2;
            end
            default: ;
        endcase
    end

    assign valp_o = pc_i + WORD_W'(len);

endmodule

// ==== rtl/y86_fetch.sv ====
`timescale 1ns/100ps

module y86_fetch import y86_pkg::*; #(
    parameter int IMEM_ADDR_W = 16
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  icode_e                 icode_i,
    input  logic                   instr_valid_i,
    input  logic                   cnd_i,
    input  logic [WORD_W-1:0]      valc_i,
    input  logic [WORD_W-1:0]      valp_i,
    input  logic [WORD_W-1:0]      valm_i,
    output logic [IMEM_ADDR_W-1:0] pc_o,
    output stat_e                  stat_o,
    output logic                   commit_o
);

    logic [IMEM_ADDR_W-1:0] pc_q;
    stat_e                  stat_q;
    logic [WORD_W-1:0]      next_pc;

    assign commit_o = rst_n_i && (stat_q == AOK) && instr_valid_i && (icode_i != I_HALT);

    always_comb begin
        case (icode_i)
            I_CALL:  next_pc = valc_i;
            I_JXX:   next_pc = cnd_i ? valc_i : valp_i;
            I_RET:   next_pc = valm_i;           // Return address from stack.
            default: next_pc = valp_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (commit_o) begin
            pc_q <= next_pc[IMEM_ADDR_W-1:0];   // Wraps at imem width.
        end
    end

    // Status sticks once the core stops.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stat_q <= AOK;
        end else if (stat_q == AOK) begin
            if (!instr_valid_i) begin
                stat_q <= INS;
            end else if (icode_i == I_HALT) begin
                stat_q <= HLT;
            end
        end
    end

    assign pc_o   = pc_q;
    assign stat_o = stat_q;

endmodule

// ==== rtl/y86_pkg.sv ====
package y86_pkg;

    localparam int WORD_W = 32;                 // Data and address width.
    localparam int INST_W = 48;                 // Six byte fetch window.
    localparam int REG_W  = 4;

    localparam logic [REG_W-1:0] REG_NONE = 4'hf;
    localparam logic [REG_W-1:0] REG_RSP  = 4'h4;

    typedef enum logic [3:0] {
        I_HALT   = 4'h0,
        I_NOP    = 4'h1,
        I_CMOVXX = 4'h2,
        I_IRMOVL = 4'h3,
        I_RMMOVL = 4'h4,
        I_MRMOVL = 4'h5,
        I_OPL    = 4'h6,
        I_JXX    = 4'h7,
        I_CALL   = 4'h8,
        I_RET    = 4'h9,
        I_PUSHL  = 4'ha,
        I_POPL   = 4'hb
    } icode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_XOR = 4'h3
    } alu_fn_e;

    // Shared by jXX and cmovXX.
    typedef enum logic [3:0] {
        C_ALWAYS = 4'h0,
        C_LE     = 4'h1,
        C_L      = 4'h2,
        C_E      = 4'h3,
        C_NE     = 4'h4,
        C_GE     = 4'h5,
        C_G      = 4'h6
    } cond_fn_e;

    typedef enum logic [1:0] {
        AOK = 2'd0,
        HLT = 2'd1,
        INS = 2'd2
    } stat_e;

endpackage
